// ==== dcache_pkg.sv ====
package dcache_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // 32-byte lines, 128 sets
    localparam int offset_w = 5;
    localparam int index_w = 7;
    localparam int tag_w = addr_w - index_w - offset_w;

    localparam int words_per_line = 8;
    localparam int word_sel_w = 3;
    localparam int data_addr_w = index_w + word_sel_w;

    localparam int nr_ways = 2;
    localparam int nr_sets = 1 << index_w;

    typedef struct packed {
        logic [tag_w-1:0]      tag;
        logic [index_w-1:0]    index;
        logic [word_sel_w-1:0] word;
        logic [1:0]            byte_off;
    } cache_addr_fields_t;

    // same 32 bits, seen raw or split into fields
    typedef union packed {
        logic [addr_w-1:0]  raw;
        cache_addr_fields_t fields;
    } cache_addr_u;

    typedef enum logic [1:0] {
        st_idle,
        st_writeback,
        st_refill,
        st_done
    } miss_state_e;

endpackage

// ==== dcache_tag_store.sv ====
`timescale 1ns/1ps

module dcache_tag_store (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic                                                   rd_en,
    input  logic [dcache_pkg::index_w-1:0]                         rd_index,
    output logic [dcache_pkg::nr_ways-1:0][dcache_pkg::tag_w-1:0] rd_tag,
    output logic [dcache_pkg::nr_ways-1:0]                         rd_valid,
    output logic [dcache_pkg::nr_ways-1:0]                         rd_dirty,
    output logic                                                   rd_lru,
    input  logic                                                   upd_en,
    input  logic [dcache_pkg::index_w-1:0]                         upd_index,
    input  logic                                                   upd_way,
    input  logic [dcache_pkg::tag_w-1:0]                           upd_tag,
    input  logic                                                   upd_valid,
    input  logic                                                   upd_dirty,
    input  logic                                                   touch_en,
    input  logic                                                   touch_way
);
    logic [dcache_pkg::nr_ways-1:0][dcache_pkg::nr_sets-1:0] valid_q;
    logic [dcache_pkg::nr_ways-1:0][dcache_pkg::nr_sets-1:0] valid_d;
    logic [dcache_pkg::nr_ways-1:0][dcache_pkg::nr_sets-1:0] dirty_q;
    logic [dcache_pkg::nr_ways-1:0][dcache_pkg::nr_sets-1:0] dirty_d;
    logic [dcache_pkg::nr_sets-1:0] lru_q;
    logic [dcache_pkg::nr_sets-1:0] lru_d;
    logic same_set;

    assign same_set = upd_en && (upd_index == rd_index);

    // next state doubles as the forwarding source
    always_comb begin
        valid_d = valid_q;
        dirty_d = dirty_q;
        lru_d = lru_q;
        if (upd_en) begin
            valid_d[upd_way][upd_index] = upd_valid;
            dirty_d[upd_way][upd_index] = upd_dirty;
        end
        if (touch_en) begin
            // the other way becomes lru
            lru_d[upd_index] = ~touch_way;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q <= '0;
        end else begin
            valid_q <= valid_d;
            dirty_q <= dirty_d;
            lru_q <= lru_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < dcache_pkg::nr_ways; w++) begin
                rd_valid[w] <= valid_d[w][rd_index];
                rd_dirty[w] <= dirty_d[w][rd_index];
            end
            rd_lru <= lru_d[rd_index];
        end
    end

    for (genvar w = 0; w < dcache_pkg::nr_ways; w++) begin : g_way
        logic [dcache_pkg::tag_w-1:0] tag_mem [dcache_pkg::nr_sets];
        logic [dcache_pkg::tag_w-1:0] tag_q;

        always_ff @(posedge clk) begin
            if (upd_en && upd_way == 1'(w)) begin
                tag_mem[upd_index] <= upd_tag;
            end
            if (rd_en) begin
                tag_q <= (same_set && upd_way == 1'(w)) ? upd_tag : tag_mem[rd_index];
            end
        end

        assign rd_tag[w] = tag_q;
    end

endmodule

// ==== dcache_data_ram.sv ====
`timescale 1ns/1ps

module dcache_data_ram (
    input  logic                               clk,
    input  logic [dcache_pkg::data_addr_w-1:0] rd_addr,
    output logic [dcache_pkg::data_w-1:0]      rd_data,
    input  logic [dcache_pkg::data_addr_w-1:0] wr_addr,
    input  logic [dcache_pkg::strb_w-1:0]      wr_strb,
    input  logic [dcache_pkg::data_w-1:0]      wr_data
);
    logic [dcache_pkg::data_w-1:0] mem [1 << dcache_pkg::data_addr_w];
    logic [dcache_pkg::data_w-1:0] merged;

    // word as it reads after this cycle's write
    always_comb begin
        merged = mem[wr_addr];
        for (int b = 0; b < dcache_pkg::strb_w; b++) begin
            if (wr_strb[b]) begin
                merged[8*b +: 8] = wr_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < dcache_pkg::strb_w; b++) begin
            if (wr_strb[b]) begin
                mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
        // write-first on an address collision
        if (|wr_strb && rd_addr == wr_addr) begin
            rd_data <= merged;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== dcache_lookup.sv ====
`timescale 1ns/1ps

module dcache_lookup (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    accept,
    input  logic                                                    wr,
    input  logic [dcache_pkg::strb_w-1:0]                           wstrb,
    input  logic [dcache_pkg::addr_w-1:0]                           addr,
    input  logic [dcache_pkg::data_w-1:0]                           wdata,
    input  logic                                                    hold,
    input  logic [dcache_pkg::nr_ways-1:0][dcache_pkg::tag_w-1:0]  tag_in,
    input  logic [dcache_pkg::nr_ways-1:0]                          valid_in,
    input  logic [dcache_pkg::nr_ways-1:0][dcache_pkg::data_w-1:0] word_in,
    output logic                                                    hit,
    output logic                                                    hit_way,
    output logic [dcache_pkg::data_w-1:0]                           load_data,
    output logic                                                    lk_wr,
    output logic [dcache_pkg::strb_w-1:0]                           lk_wstrb,
    output logic [dcache_pkg::addr_w-1:0]                           lk_addr,
    output logic [dcache_pkg::data_w-1:0]                           lk_wdata,
    output logic                                                    lk_busy
);
    dcache_pkg::cache_addr_u lk_a;
    logic [dcache_pkg::nr_ways-1:0] way_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            lk_busy <= 1'b0;
        end else if (accept) begin
            lk_busy <= 1'b1;
        end else if (!hold) begin
            lk_busy <= 1'b0;
        end
    end

    // request stays put while a miss is served
    always_ff @(posedge clk) begin
        if (accept) begin
            lk_wr <= wr;
            lk_wstrb <= wstrb;
            lk_addr <= addr;
            lk_wdata <= wdata;
        end
    end

    assign lk_a.raw = lk_addr;

    always_comb begin
        for (int w = 0; w < dcache_pkg::nr_ways; w++) begin
            way_hit[w] = valid_in[w] && (tag_in[w] == lk_a.fields.tag);
        end
    end

    assign hit = lk_busy && |way_hit;
    assign hit_way = way_hit[1];
    assign load_data = word_in[hit_way];

endmodule

// ==== dcache_miss_ctrl.sv ====
`timescale 1ns/1ps

module dcache_miss_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               lk_busy,
    input  logic                               hit,
    input  logic                               lk_wr,
    input  logic [dcache_pkg::strb_w-1:0]      lk_wstrb,
    input  logic [dcache_pkg::addr_w-1:0]      lk_addr,
    input  logic [dcache_pkg::data_w-1:0]      lk_wdata,
    input  logic                               victim_way,
    input  logic                               victim_dirty,
    input  logic [dcache_pkg::tag_w-1:0]       victim_tag,
    input  logic [dcache_pkg::data_w-1:0]      victim_word,
    output logic [dcache_pkg::data_addr_w-1:0] wb_rd_addr,
    output logic                               fill_way,
    output logic [dcache_pkg::data_addr_w-1:0] fill_addr,
    output logic [dcache_pkg::strb_w-1:0]      fill_strb,
    output logic [dcache_pkg::data_w-1:0]      fill_data,
    output logic                               upd_en,
    output logic                               stall,
    output logic [dcache_pkg::data_w-1:0]      miss_rdata,
    output logic                               done,
    output logic [dcache_pkg::addr_w-1:0]      araddr,
    output logic                               arvalid,
    input  logic                               arready,
    input  logic [dcache_pkg::data_w-1:0]      rdata_bus,
    input  logic                               rlast,
    input  logic                               rvalid,
    output logic                               rready,
    output logic [dcache_pkg::addr_w-1:0]      awaddr,
    output logic                               awvalid,
    input  logic                               awready,
    output logic [dcache_pkg::data_w-1:0]      wdata_bus,
    output logic                               wlast,
    output logic                               wvalid,
    input  logic                               wready,
    input  logic                               bvalid
);
    dcache_pkg::miss_state_e state;
    dcache_pkg::cache_addr_u req_a;
    dcache_pkg::cache_addr_u wb_a;
    dcache_pkg::cache_addr_u fill_a;
    logic [dcache_pkg::data_w-1:0] line_buf [dcache_pkg::words_per_line];
    logic [dcache_pkg::word_sel_w:0] rd_cnt;
    logic [dcache_pkg::word_sel_w:0] beat_cnt;
    logic [dcache_pkg::word_sel_w-1:0] fill_cnt;
    logic beat;
    logic buf_full;

    assign req_a.raw = lk_addr;

    // line base addresses
    always_comb begin
        wb_a.raw = req_a.raw;
        wb_a.fields.tag = victim_tag;
        wb_a.fields.word = '0;
        wb_a.fields.byte_off = '0;
        fill_a.raw = req_a.raw;
        fill_a.fields.word = '0;
        fill_a.fields.byte_off = '0;
    end

    assign araddr = fill_a.raw;
    assign beat = rvalid && rready;
    // one extra count for the read latency of the bank
    assign buf_full = (rd_cnt == dcache_pkg::words_per_line + 1);
    assign wb_rd_addr = {req_a.fields.index, rd_cnt[dcache_pkg::word_sel_w-1:0]};
    assign fill_addr = {req_a.fields.index, fill_cnt};
    assign fill_strb = beat ? '1 : '0;
    assign wdata_bus = line_buf[beat_cnt[dcache_pkg::word_sel_w-1:0]];
    assign wlast = (beat_cnt == dcache_pkg::words_per_line - 1);
    assign upd_en = beat && rlast;
    assign done = (state == dcache_pkg::st_done);
    assign stall = (state == dcache_pkg::st_idle && lk_busy && !hit)
                || state == dcache_pkg::st_writeback
                || state == dcache_pkg::st_refill;

    // store bytes merged into the target word of the refill
    always_comb begin
        fill_data = rdata_bus;
        if (lk_wr && fill_cnt == req_a.fields.word) begin
            for (int b = 0; b < dcache_pkg::strb_w; b++) begin
                if (lk_wstrb[b]) begin
                    fill_data[8*b +: 8] = lk_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::st_idle;
            arvalid <= 1'b0;
            rready <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            rd_cnt <= '0;
            beat_cnt <= '0;
            fill_cnt <= '0;
        end else begin
            case (state)
                dcache_pkg::st_idle: begin
                    rd_cnt <= '0;
                    beat_cnt <= '0;
                    fill_cnt <= '0;
                    if (lk_busy && !hit) begin
                        if (victim_dirty) begin
                            state <= dcache_pkg::st_writeback;
                            awvalid <= 1'b1;
                        end else begin
                            state <= dcache_pkg::st_refill;
                            arvalid <= 1'b1;
                        end
                    end
                end
                dcache_pkg::st_writeback: begin
                    if (!buf_full) begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    // data goes out once the address is taken and the line is buffered
                    if (buf_full && !awvalid && !wvalid && beat_cnt == 0) begin
                        wvalid <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (wlast) begin
                            wvalid <= 1'b0;
                        end
                    end
                    if (bvalid && beat_cnt == dcache_pkg::words_per_line) begin
                        state <= dcache_pkg::st_refill;
                        arvalid <= 1'b1;
                    end
                end
                dcache_pkg::st_refill: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                    end
                    if (beat) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (rlast) begin
                            rready <= 1'b0;
                            state <= dcache_pkg::st_done;
                        end
                    end
                end
                default: begin
                    state <= dcache_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::st_idle) begin
            fill_way <= victim_way;
            awaddr <= wb_a.raw;
        end
        if (state == dcache_pkg::st_writeback && rd_cnt != 0 && !buf_full) begin
            line_buf[rd_cnt[dcache_pkg::word_sel_w-1:0] - 1'b1] <= victim_word;
        end
        if (beat && fill_cnt == req_a.fields.word) begin
            miss_rdata <= fill_data;
        end
    end

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    input  logic                          wr,
    input  logic [dcache_pkg::strb_w-1:0] wstrb,
    input  logic [dcache_pkg::addr_w-1:0] addr,
    input  logic [dcache_pkg::data_w-1:0] wdata,
    output logic [dcache_pkg::data_w-1:0] rdata,
    output logic                          stall,
    output logic [dcache_pkg::addr_w-1:0] araddr,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [dcache_pkg::data_w-1:0] rdata_bus,
    input  logic                          rlast,
    input  logic                          rvalid,
    output logic                          rready,
    output logic [dcache_pkg::addr_w-1:0] awaddr,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [dcache_pkg::data_w-1:0] wdata_bus,
    output logic                          wlast,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic                          bvalid
);
    dcache_pkg::cache_addr_u core_a;
    dcache_pkg::cache_addr_u lk_a;
    logic accept;
    logic lk_wr;
    logic [dcache_pkg::strb_w-1:0] lk_wstrb;
    logic [dcache_pkg::addr_w-1:0] lk_addr;
    logic [dcache_pkg::data_w-1:0] lk_wdata;
    logic lk_busy;
    logic hit;
    logic hit_way;
    logic hit_st;
    logic acc_way;
    logic [dcache_pkg::data_w-1:0] load_data;
    logic [dcache_pkg::nr_ways-1:0][dcache_pkg::tag_w-1:0] rd_tag;
    logic [dcache_pkg::nr_ways-1:0] rd_valid;
    logic [dcache_pkg::nr_ways-1:0] rd_dirty;
    logic rd_lru;
    logic [dcache_pkg::nr_ways-1:0][dcache_pkg::data_w-1:0] ram_rd_data;
    logic [dcache_pkg::data_addr_w-1:0] ram_rd_addr;
    logic [dcache_pkg::data_addr_w-1:0] ram_wr_addr;
    logic [dcache_pkg::data_w-1:0] ram_wr_data;
    logic [dcache_pkg::data_addr_w-1:0] wb_rd_addr;
    logic [dcache_pkg::data_addr_w-1:0] fill_addr;
    logic fill_way;
    logic [dcache_pkg::strb_w-1:0] fill_strb;
    logic [dcache_pkg::data_w-1:0] fill_data;
    logic [dcache_pkg::data_w-1:0] miss_rdata;
    logic upd_en;
    logic done;

    assign core_a.raw = addr;
    assign lk_a.raw = lk_addr;
    assign accept = req && !stall;
    assign hit_st = hit && lk_wr;
    // way touched by this access, hit way or refilled victim
    assign acc_way = hit ? hit_way : fill_way;
    assign rdata = done ? miss_rdata : load_data;
    // victim line is read out while the core is stalled
    assign ram_rd_addr = stall ? wb_rd_addr : {core_a.fields.index, core_a.fields.word};
    assign ram_wr_addr = hit_st ? {lk_a.fields.index, lk_a.fields.word} : fill_addr;
    assign ram_wr_data = hit_st ? lk_wdata : fill_data;

    dcache_lookup dcache_lookup_i (
        .clk(clk), .rst(rst), .accept(accept), .wr(wr), .wstrb(wstrb), .addr(addr),
        .wdata(wdata), .hold(stall), .tag_in(rd_tag), .valid_in(rd_valid),
        .word_in(ram_rd_data), .hit(hit), .hit_way(hit_way), .load_data(load_data),
        .lk_wr(lk_wr), .lk_wstrb(lk_wstrb), .lk_addr(lk_addr), .lk_wdata(lk_wdata),
        .lk_busy(lk_busy)
    );

    dcache_tag_store dcache_tag_store_i (
        .clk(clk), .rst(rst), .rd_en(accept), .rd_index(core_a.fields.index),
        .rd_tag(rd_tag), .rd_valid(rd_valid), .rd_dirty(rd_dirty), .rd_lru(rd_lru),
        .upd_en(upd_en || hit_st), .upd_index(lk_a.fields.index), .upd_way(acc_way),
        .upd_tag(lk_a.fields.tag), .upd_valid(1'b1), .upd_dirty(lk_wr),
        .touch_en(hit || upd_en), .touch_way(acc_way)
    );

    for (genvar w = 0; w < dcache_pkg::nr_ways; w++) begin : g_way
        logic [dcache_pkg::strb_w-1:0] wr_strb;

        assign wr_strb = hit_st ? (hit_way == 1'(w) ? lk_wstrb : '0)
                                : (fill_way == 1'(w) ? fill_strb : '0);

        dcache_data_ram dcache_data_ram_i (
            .clk(clk), .rd_addr(ram_rd_addr), .rd_data(ram_rd_data[w]),
            .wr_addr(ram_wr_addr), .wr_strb(wr_strb), .wr_data(ram_wr_data)
        );
    end

    dcache_miss_ctrl dcache_miss_ctrl_i (
        .clk(clk), .rst(rst), .lk_busy(lk_busy), .hit(hit), .lk_wr(lk_wr),
        .lk_wstrb(lk_wstrb), .lk_addr(lk_addr), .lk_wdata(lk_wdata),
        .victim_way(rd_lru), .victim_dirty(rd_dirty[rd_lru]), .victim_tag(rd_tag[rd_lru]),
        .victim_word(ram_rd_data[fill_way]), .wb_rd_addr(wb_rd_addr), .fill_way(fill_way),
        .fill_addr(fill_addr), .fill_strb(fill_strb), .fill_data(fill_data),
        .upd_en(upd_en), .stall(stall), .miss_rdata(miss_rdata), .done(done),
        .araddr(araddr), .arvalid(arvalid), .arready(arready), .rdata_bus(rdata_bus),
        .rlast(rlast), .rvalid(rvalid), .rready(rready), .awaddr(awaddr),
        .awvalid(awvalid), .awready(awready), .wdata_bus(wdata_bus), .wlast(wlast),
        .wvalid(wvalid), .wready(wready), .bvalid(bvalid)
    );

endmodule

// ==== dcache_mem_model.sv ====
`timescale 1ns/1ps

module dcache_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  delay,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata_bus,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata_bus,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    output logic [31:0] wb_word_addr,
    input  logic [31:0] wb_expect,
    output int          wb_errors,
    output int          ar_count,
    output logic [31:0] last_araddr,
    output int          aw_count,
    output logic [31:0] last_awaddr
);
    // 16 KB backing store with the shadow's fill pattern
    logic [31:0] mem [4096];

    task automatic wait_delay();
        int n;
        n = delay;
        repeat (n) @(negedge clk);
    endtask

    task automatic serve_read();
        logic [31:0] base;
        wait_delay();
        @(negedge clk) arready = 1'b1;
        @(posedge clk);
        base = araddr;
        ar_count++;
        last_araddr = base;
        @(negedge clk) arready = 1'b0;
        for (int i = 0; i < 8; i++) begin
            wait_delay();
            @(negedge clk);
            rvalid = 1'b1;
            rlast = (i == 7);
            rdata_bus = mem[(base[13:2] + i) % 4096];
            do @(posedge clk); while (!rready);
            @(negedge clk);
            rvalid = 1'b0;
            rlast = 1'b0;
        end
    endtask

    task automatic serve_write();
        logic [31:0] base;
        wait_delay();
        @(negedge clk) awready = 1'b1;
        @(posedge clk);
        base = awaddr;
        aw_count++;
        last_awaddr = base;
        @(negedge clk) awready = 1'b0;
        for (int i = 0; i < 8; i++) begin
            wait_delay();
            @(negedge clk);
            wb_word_addr = base + 4 * i;
            wready = 1'b1;
            do @(posedge clk); while (!wvalid);
            assert (wdata_bus === wb_expect) else begin
                $display("[ERROR] wdata_bus at %h expected %h got %h",
                         wb_word_addr, wb_expect, wdata_bus);
                wb_errors++;
            end
            assert (wlast === (i == 7)) else begin
                $display("[ERROR] wlast at %h expected %h got %h",
                         wb_word_addr, (i == 7), wlast);
                wb_errors++;
            end
            mem[wb_word_addr[13:2]] = wdata_bus;
            @(negedge clk) wready = 1'b0;
        end
        @(negedge clk) bvalid = 1'b1;
        @(negedge clk) bvalid = 1'b0;
    endtask

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = (i * 4) ^ 32'h5a3c_96e1;
        end
        {arready, rvalid, rlast, awready, wready, bvalid} = '0;
        rdata_bus = '0;
        wb_word_addr = '0;
        wb_errors = 0;
        ar_count = 0;
        aw_count = 0;
        last_araddr = '0;
        last_awaddr = '0;
        forever begin
            @(posedge clk);
            if (!rst && awvalid) begin
                serve_write();
            end else if (!rst && arvalid) begin
                serve_read();
            end
        end
    end

endmodule

// ==== dcache_sva.sv ====
`timescale 1ns/1ps

module dcache_sva (
    input logic        clk,
    input logic        rst,
    input logic [31:0] araddr,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] awaddr,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] wdata_bus,
    input logic        wlast,
    input logic        wvalid,
    input logic        wready
);
    int fail_count = 0;

    // valid holds with a stable address until ready
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("arvalid dropped or araddr changed before arready");
            fail_count++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            $error("awvalid dropped or awaddr changed before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else begin
            $error("wvalid dropped before wready");
            fail_count++;
        end

    // a stalled write beat keeps its data
    w_data_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> $stable(wdata_bus) && $stable(wlast))
        else begin
            $error("wdata_bus or wlast changed before wready");
            fail_count++;
        end

endmodule

bind dcache_top dcache_sva dcache_sva_i (
    .clk(clk), .rst(rst), .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata_bus(wdata_bus),
    .wlast(wlast), .wvalid(wvalid), .wready(wready)
);

// ==== dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    localparam int n_ops = 450;
    localparam int worst_miss_cycles = 120;
    localparam realtime timeout = (16 + n_ops * worst_miss_cycles) * 40.0;

    logic clk;
    logic rst;
    logic req;
    logic wr;
    logic [3:0] wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic stall;
    logic [31:0] araddr;
    logic [31:0] awaddr;
    logic [31:0] rdata_bus;
    logic [31:0] wdata_bus;
    logic arvalid;
    logic arready;
    logic rlast;
    logic rvalid;
    logic rready;
    logic awvalid;
    logic awready;
    logic wlast;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic [1:0] ready_delay;
    logic [31:0] wb_word_addr;
    logic [31:0] wb_expect;
    int wb_errors;
    int ar_count;
    int aw_count;
    logic [31:0] last_araddr;
    logic [31:0] last_awaddr;

    logic [31:0] shadow [4096];
    logic [31:0] stim_state;
    logic [31:0] delay_state;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;
    logic [31:0] cmp_addr;
    event cmp_ev;
    int errors;
    int checks;

    dcache_top dcache_top_i (.*);

    dcache_mem_model dcache_mem_model_i (.*, .delay(ready_delay));

    assign wb_expect = shadow[wb_word_addr[13:2]];

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] next_rand();
        stim_state = lcg_next(stim_state);
        return stim_state[31:16];
    endfunction

    function automatic logic [31:0] ref_load(input logic [31:0] a);
        return shadow[a[13:2]];
    endfunction

    function automatic int total_errors();
        return errors + wb_errors + dcache_top_i.dcache_sva_i.fail_count;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        delay_state <= lcg_next(delay_state);
        ready_delay <= delay_state[17:16];
    end

    initial begin
        forever begin
            @(cmp_ev);
            checks++;
            assert (cmp_act === cmp_exp) else begin
                $display("[ERROR] rdata at %h expected %h got %h", cmp_addr, cmp_exp, cmp_act);
                errors++;
            end
        end
    end

    initial begin
        #(timeout);
        $display("watchdog expired before the tests completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // starts at a falling edge, returns at the falling edge where the result is valid
    task automatic access(input logic w, input logic [3:0] s, input logic [31:0] a,
                          input logic [31:0] d, output logic missed);
        logic [31:0] exp;
        req = 1'b1;
        wr = w;
        wstrb = s;
        addr = a;
        wdata = d;
        exp = ref_load(a);
        if (w) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    shadow[a[13:2]][8*b +: 8] = d[8*b +: 8];
                end
            end
        end
        @(posedge clk);
        @(negedge clk);
        req = 1'b0;
        missed = stall;
        while (stall) @(negedge clk);
        if (!w) begin
            cmp_addr = a;
            cmp_exp = exp;
            cmp_act = rdata;
            ->cmp_ev;
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic confirm(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s: %s", name, total_errors() == err_before ? "ok" : "errors");
    endtask

    initial begin
        logic m;
        logic [3:0] s;
        logic [31:0] a;
        int e0;
        int ar0;
        int aw0;
        stim_state = 32'd37286;
        delay_state = lcg_next(32'd37286);
        ready_delay = 2'd0;
        errors = 0;
        checks = 0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = (i * 4) ^ 32'h5a3c_96e1;
        end
        {req, wr, wstrb, addr, wdata} = '0;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        @(negedge clk);

        e0 = total_errors();
        confirm(!stall && !arvalid && !awvalid && !wvalid && !rready,
                "control outputs not low after reset");
        report_test("reset", e0);

        e0 = total_errors();
        ar0 = ar_count;
        access(0, 4'h0, 32'h1048, 0, m);
        confirm(m, "load to an empty line did not stall");
        compare_value("ar_count", ar0 + 1, ar_count);
        compare_value("araddr", 32'h1040, last_araddr);
        for (int i = 0; i < 8; i++) begin
            access(0, 4'h0, 32'h1040 + 4 * i, 0, m);
            confirm(!m, "load to a filled line stalled");
        end
        report_test("load miss refill", e0);

        e0 = total_errors();
        access(1, 4'b0101, 32'h104c, 32'haabb_ccdd, m);
        confirm(!m, "store hit stalled");
        access(0, 4'h0, 32'h104c, 0, m);
        confirm(!m, "load after store hit stalled");
        report_test("store hit then load", e0);

        e0 = total_errors();
        access(1, 4'b1100, 32'h2064, 32'h1234_5678, m);
        confirm(m, "store to an empty line did not stall");
        access(0, 4'h0, 32'h2064, 0, m);
        confirm(!m, "load to the line allocated by a store stalled");
        report_test("store miss allocate", e0);

        e0 = total_errors();
        access(1, 4'hf, 32'h00a4, 32'hdead_beef, m);
        access(1, 4'b0011, 32'h10a8, 32'hcafe_f00d, m);
        aw0 = aw_count;
        access(0, 4'h0, 32'h20a0, 0, m);
        compare_value("aw_count", aw0 + 1, aw_count);
        compare_value("awaddr", 32'h00a0, last_awaddr);
        access(0, 4'h0, 32'h00a4, 0, m);
        access(0, 4'h0, 32'h10a8, 0, m);
        report_test("dirty eviction", e0);

        e0 = total_errors();
        for (int i = 0; i < 400; i++) begin
            a = {18'd0, next_rand() % 4 == 0 ? 2'd0 : 2'(next_rand()), 7'd8 + 7'(next_rand() % 4),
                 3'(next_rand()), 2'b00};
            if (next_rand() % 2 == 1) begin
                s = 4'(next_rand());
                access(1, s == 0 ? 4'hf : s, a, {next_rand(), next_rand()}, m);
            end else begin
                access(0, 4'h0, a, 0, m);
            end
        end
        report_test("random traffic", e0);

        @(negedge clk);
        $display("summary: %0d checks, %0d errors", checks, total_errors());
        if (total_errors() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
dcache_pkg.sv
dcache_tag_store.sv
dcache_data_ram.sv
dcache_lookup.sv
dcache_miss_ctrl.sv
dcache_top.sv
dcache_mem_model.sv
dcache_sva.sv
dcache_tb.sv
